//--- build.f
+incdir+tests
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/instr_mem.sv
design/insn_decoder.sv
design/reg_file.sv
design/alu.sv
design/pc_unit.sv
design/rv_core_top.sv
tests/tb_rv_core.sv

//--- tests/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state of the reference model
logic [31:0] m_regs [32];
logic [31:0] m_pc;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

// off is the byte offset, bit 0 is dropped by the format
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = {31'b0, $signed(a) < $signed(b)};
    3'd3: r = {31'b0, a < b};
    3'd4: r = a ^ b;
    3'd5: begin
      // kept apart from the ?: so the arithmetic shift stays signed
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// expected commit, next pc and halt for the instruction at m_pc
function automatic void ref_exec(input logic [31:0] insn, output rv_core_pkg::commit_t exp,
                                 output logic [31:0] npc, output logic halts);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  a     = m_regs[insn[19:15]];
  b     = m_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  exp    = '0;
  exp.pc = m_pc;
  npc    = m_pc + 32'd4;
  halts  = 1'b0;
  case (insn[6:0])
    7'b0110111: begin
      exp.we   = 1'b1;
      exp.rd   = insn[11:7];
      exp.data = {insn[31:12], 12'b0};
    end
    7'b0010011: begin
      exp.we   = 1'b1;
      exp.rd   = insn[11:7];
      exp.data = alu_calc(insn[14:12], insn[30] && insn[14:12] == 3'd5, a, imm_i);
    end
    7'b0110011: begin
      exp.we   = 1'b1;
      exp.rd   = insn[11:7];
      exp.data = alu_calc(insn[14:12], insn[30], a, b);
    end
    7'b1100011: begin
      if (branch_cond(insn[14:12], a, b)) begin
        npc = m_pc + imm_b;
      end
    end
    7'b1110011: halts = 1'b1;
    default: halts = 1'b0;
  endcase
endfunction

function automatic void model_step(input rv_core_pkg::commit_t c, input logic [31:0] npc);
  if (c.we && c.rd != 5'd0) begin
    m_regs[c.rd] = c.data;
  end
  m_pc = npc;
endfunction

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc = '0;
endfunction

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int IMEM_WORDS = 256;
  localparam int AW         = $clog2(IMEM_WORDS);
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int SEED_REGS  = 8;
  localparam int RAND_INSNS = 40;
  localparam int ECALL_IDX  = 2 * SEED_REGS + RAND_INSNS;
  localparam int NUM_PROGS  = 2;
  // reset, load and run of every program plus slack times four
  localparam int LIMIT_CYCLES =
    (NUM_PROGS * (RST_CYCLES + IMEM_WORDS + ECALL_IDX + 1) + 20) * 4;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 imem_we;
  logic [AW-1:0]        imem_addr;
  logic [31:0]          imem_wdata;
  logic                 run;
  logic                 halt;
  logic                 commit_valid;
  rv_core_pkg::commit_t commit;

  integer      seed    = 32'hf3cbe2c5;
  int          errors  = 0;
  int          commits = 0;
  logic [31:0] prog [IMEM_WORDS];
  logic        m_halted;
  logic [31:0] m_halt_pc;
  logic [31:0] last_pc;

  `include "rv_ref_model.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_core_top #(
    .IMEM_WORDS(IMEM_WORDS)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .run         (run),
    .halt        (halt),
    .commit_valid(commit_valid),
    .commit      (commit)
  );

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // compares every commit with the model, then steps the model
  always @(posedge clk) begin
    rv_core_pkg::commit_t exp;
    logic [31:0]          npc;
    logic                 halts;
    assert (run || !commit_valid) else report_error("commit seen while run is low");
    assert (!(halt && commit_valid)) else report_error("commit seen while halted");
    if (commit_valid) begin
      assert (!m_halted) else report_error("commit after the ecall retired");
      ref_exec(prog[m_pc[AW+1:2]], exp, npc, halts);
      check_word("commit.pc", commit.pc, exp.pc);
      check_word("commit.rd", commit.rd, exp.rd);
      check_word("commit.we", commit.we, exp.we);
      check_word("commit.data", commit.data, exp.data);
      last_pc = commit.pc;
      commits++;
      if (halts) begin
        m_halted  = 1'b1;
        m_halt_pc = m_pc;
      end
      model_step(exp, npc);
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    model_reset();
    m_halted = 1'b0;
  endtask

  // seed pairs, random body with forward branches, ecall fill
  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          k;
    int          steps;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      prog[i] = 32'h00000073;
    end
    for (int s = 1; s <= SEED_REGS; s++) begin
      r = $random(seed);
      prog[2 * s - 2] = enc_u(r[31:12], s[4:0]);
      prog[2 * s - 1] = enc_i(r[11:0], s[4:0], 3'd0, s[4:0]);
    end
    for (int i = 2 * SEED_REGS; i < ECALL_IDX; i++) begin
      r   = $random(seed);
      r2  = $random(seed);
      rs2 = r[14:10];
      f3  = r[17:15];
      case (r[21:20])
        2'd0: begin
          prog[i] = enc_r((r[18] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          rs2, r[9:5], f3, r[4:0]);
        end
        2'd1: begin
          if (f3 == 3'd1) begin
            imm = {7'h00, rs2};
          end else if (f3 == 3'd5) begin
            imm = {r[18] ? 7'h20 : 7'h00, rs2};
          end else begin
            imm = r2[11:0];
          end
          prog[i] = enc_i(imm, r[9:5], f3, r[4:0]);
        end
        2'd2: begin
          k     = r2 % 6;
          f3    = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
          steps = r[23:22] + 1;
          if (steps > ECALL_IDX - i) begin
            steps = ECALL_IDX - i;
          end
          // equal operands now and then so beq and bge get taken
          prog[i] = enc_b(13'(steps * 4), r[24] ? r[9:5] : rs2, r[9:5], f3);
        end
        default: prog[i] = enc_u(r2[19:0], r[4:0]);
      endcase
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= i[AW-1:0];
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic run_program();
    @(posedge clk);
    assert (!halt) else report_error("halt is high before run rises");
    run <= 1'b1;
    // a load attempt while running would turn the final ecall into a nop
    imem_we    <= 1'b1;
    imem_addr  <= AW'(ECALL_IDX);
    imem_wdata <= enc_i(12'd0, 5'd0, 3'd0, 5'd0);
    @(posedge clk);
    imem_we <= 1'b0;
    while (!halt) begin
      @(posedge clk);
    end
    repeat (4) begin
      @(posedge clk);
      assert (halt) else report_error("halt dropped without a reset");
    end
    run <= 1'b0;
    assert (m_halted) else report_error("core halted before the model reached ecall");
    check_word("halt pc", last_pc, m_halt_pc);
  endtask

  initial begin
    rst        = 1'b1;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    m_halted   = 1'b0;
    m_halt_pc  = '0;
    last_pc    = '0;
    model_reset();
    for (int p = 0; p < NUM_PROGS; p++) begin
      apply_reset();
      gen_program();
      load_program();
      run_program();
    end
    @(posedge clk);
    $display("errors: %0d, commits checked: %0d", errors, commits);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the core did not reach halt in the expected time");
    $display("errors: %0d, commits checked: %0d", errors, commits);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
  input  rv_isa_pkg::word_t             imem_wdata,
  input  logic                          run,
  output logic                          halt,
  output logic                          commit_valid,
  output rv_core_pkg::commit_t          commit
);

  rv_isa_pkg::word_t     pc;
  rv_isa_pkg::word_t     insn;
  rv_core_pkg::decoded_t dec;
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  rv_isa_pkg::word_t     result;
  rv_isa_pkg::word_t     wb_data;
  logic                  taken;
  logic                  advance;
  logic                  load_we;
  logic                  rf_we;

  assign advance = run && !halt;
  // the program can only be changed while the core is stopped
  assign load_we = imem_we && !run;
  assign rf_we   = dec.reg_we && advance;
  assign wb_data = dec.is_lui ? dec.imm : result;

  instr_mem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) imem_i (
    .clk  (clk),
    .we   (load_we),
    .waddr(imem_addr),
    .wdata(imem_wdata),
    .pc   (pc),
    .insn (insn)
  );

  insn_decoder dec_i (
    .insn(insn),
    .dec (dec)
  );

  reg_file rf_i (
    .clk     (clk),
    .rst     (rst),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (rf_we),
    .rd      (dec.rd),
    .rd_data (wb_data)
  );

  alu alu_i (
    .dec     (dec),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .result  (result),
    .taken   (taken)
  );

  pc_unit pc_i (
    .clk    (clk),
    .rst    (rst),
    .advance(advance),
    .dec    (dec),
    .taken  (taken),
    .pc     (pc),
    .halt   (halt)
  );

  // trace of the instruction retiring this cycle
  assign commit_valid = advance;
  assign commit.pc    = pc;
  assign commit.we    = dec.reg_we;
  // rd and data read as zero when nothing is written back
  assign commit.rd    = dec.reg_we ? dec.rd : '0;
  assign commit.data  = dec.reg_we ? wb_data : '0;

endmodule

`default_nettype wire

//--- design/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  advance,
  input  rv_core_pkg::decoded_t dec,
  input  logic                  taken,
  output rv_isa_pkg::word_t     pc,
  output logic                  halt
);

  rv_isa_pkg::word_t next_pc;

  // branch target is relative to the branch itself
  assign next_pc = (dec.is_branch && taken) ? pc + dec.imm : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (advance) begin
      pc <= next_pc;
    end
  end

  // sticky until reset, ecall still retires in its own cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (advance && dec.is_ecall) begin
      halt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_core_pkg::decoded_t dec,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  output rv_isa_pkg::word_t     result,
  output logic                  taken
);

  rv_isa_pkg::word_t opb;
  logic [4:0]        shamt;
  logic              lt_s;
  logic              lt_u;

  assign opb   = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = opb[4:0];

  // shared by slt/sltu and the ordered branches
  assign lt_s = $signed(rs1_data) < $signed(opb);
  assign lt_u = rs1_data < opb;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (dec.alu_op)
      rv_core_pkg::ALU_ADD:  result = rs1_data + opb;
      rv_core_pkg::ALU_SUB:  result = rs1_data - opb;
      rv_core_pkg::ALU_SLL:  result = rs1_data << shamt;
      rv_core_pkg::ALU_SLT:  result = {31'b0, lt_s};
      rv_core_pkg::ALU_SLTU: result = {31'b0, lt_u};
      rv_core_pkg::ALU_XOR:  result = rs1_data ^ opb;
      rv_core_pkg::ALU_SRL:  result = rs1_data >> shamt;
      rv_core_pkg::ALU_SRA:  result = $signed(rs1_data) >>> shamt;
      rv_core_pkg::ALU_OR:   result = rs1_data | opb;
      rv_core_pkg::ALU_AND:  result = rs1_data & opb;
      // branches compare rs1 with rs2, use_imm is clear for them
      rv_core_pkg::ALU_BEQ:  taken = (rs1_data == opb);
      rv_core_pkg::ALU_BNE:  taken = (rs1_data != opb);
      rv_core_pkg::ALU_BLT:  taken = lt_s;
      rv_core_pkg::ALU_BGE:  taken = !lt_s;
      rv_core_pkg::ALU_BLTU: taken = lt_u;
      default:               taken = !lt_u;
    endcase
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data
);

  rv_isa_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 is forced on the read side as well
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  rv_isa_pkg::word_t     insn,
  output rv_core_pkg::decoded_t dec
);

  rv_isa_pkg::insn_fields_t f;
  rv_isa_pkg::word_t        imm_i;
  rv_isa_pkg::word_t        imm_b;
  rv_isa_pkg::word_t        imm_u;

  assign f = rv_isa_pkg::insn_fields_t'(insn);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  // b-type offset is scattered over funct7 and rd
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec           = '0;
    dec.alu_op    = rv_core_pkg::ALU_ADD;
    dec.rs1       = f.rs1;
    dec.rs2       = f.rs2;
    dec.rd        = f.rd;
    dec.imm       = imm_i;

    case (f.opcode)
      rv_isa_pkg::OP_LUI: begin
        dec.imm    = imm_u;
        dec.is_lui = 1'b1;
        dec.reg_we = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
        case (f.funct3)
          rv_isa_pkg::F3_ADD_SUB: dec.alu_op = rv_core_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT:     dec.alu_op = rv_core_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU:    dec.alu_op = rv_core_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:     dec.alu_op = rv_core_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:      dec.alu_op = rv_core_pkg::ALU_OR;
          rv_isa_pkg::F3_AND:     dec.alu_op = rv_core_pkg::ALU_AND;
          rv_isa_pkg::F3_SLL: begin
            dec.alu_op  = rv_core_pkg::ALU_SLL;
            dec.illegal = (f.funct7 != 7'b0);
          end
          default: begin
            // srli or srai, told apart by the upper immediate bits
            if (f.funct7 == 7'b0) begin
              dec.alu_op = rv_core_pkg::ALU_SRL;
            end else if (f.funct7 == rv_isa_pkg::FUNCT7_ALT) begin
              dec.alu_op = rv_core_pkg::ALU_SRA;
            end else begin
              dec.illegal = 1'b1;
            end
          end
        endcase
      end
      rv_isa_pkg::OP_REG: begin
        dec.reg_we = 1'b1;
        if (f.funct7 == 7'b0) begin
          case (f.funct3)
            rv_isa_pkg::F3_ADD_SUB: dec.alu_op = rv_core_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     dec.alu_op = rv_core_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     dec.alu_op = rv_core_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    dec.alu_op = rv_core_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     dec.alu_op = rv_core_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: dec.alu_op = rv_core_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      dec.alu_op = rv_core_pkg::ALU_OR;
            default:                dec.alu_op = rv_core_pkg::ALU_AND;
          endcase
        end else if (f.funct7 == rv_isa_pkg::FUNCT7_ALT &&
                     f.funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          dec.alu_op = rv_core_pkg::ALU_SUB;
        end else if (f.funct7 == rv_isa_pkg::FUNCT7_ALT &&
                     f.funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          dec.alu_op = rv_core_pkg::ALU_SRA;
        end else begin
          // includes the multiply/divide group
          dec.illegal = 1'b1;
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        case (f.funct3)
          rv_isa_pkg::F3_BEQ:  dec.alu_op = rv_core_pkg::ALU_BEQ;
          rv_isa_pkg::F3_BNE:  dec.alu_op = rv_core_pkg::ALU_BNE;
          rv_isa_pkg::F3_BLT:  dec.alu_op = rv_core_pkg::ALU_BLT;
          rv_isa_pkg::F3_BGE:  dec.alu_op = rv_core_pkg::ALU_BGE;
          rv_isa_pkg::F3_BLTU: dec.alu_op = rv_core_pkg::ALU_BLTU;
          rv_isa_pkg::F3_BGEU: dec.alu_op = rv_core_pkg::ALU_BGEU;
          default:             dec.illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // only the all-zero form is ecall
        if (insn[31:7] == 25'b0) begin
          dec.is_ecall = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // illegal words just fall through to pc + 4
    if (dec.illegal) begin
      dec.reg_we    = 1'b0;
      dec.is_branch = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(IMEM_WORDS)-1:0] waddr,
  input  rv_isa_pkg::word_t             wdata,
  input  rv_isa_pkg::word_t             pc,
  output rv_isa_pkg::word_t             insn
);

  localparam int ADDR_W = $clog2(IMEM_WORDS);

  rv_isa_pkg::word_t mem [IMEM_WORDS];

  logic [ADDR_W-1:0] raddr;

  // byte address to word index
  assign raddr = pc[ADDR_W+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch is combinational so the core stays single cycle
  assign insn = mem[raddr];

endmodule

`default_nettype wire

//--- design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // arithmetic ops first, branch compares after
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  typedef struct packed {
    alu_op_e               alu_op;
    rv_isa_pkg::reg_idx_t  rs1;
    rv_isa_pkg::reg_idx_t  rs2;
    rv_isa_pkg::reg_idx_t  rd;
    rv_isa_pkg::word_t     imm;
    logic                  use_imm;
    logic                  is_lui;
    logic                  is_branch;
    logic                  is_ecall;
    logic                  illegal;
    logic                  reg_we;
  } decoded_t;

  // one retired instruction as seen at the top level
  typedef struct packed {
    rv_isa_pkg::word_t     pc;
    rv_isa_pkg::reg_idx_t  rd;
    rv_isa_pkg::word_t     data;
    logic                  we;
  } commit_t;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for register-immediate and register-register ops
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_alu_e;

  // 3'b010 and 3'b011 are unused in the branch group
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } funct3_br_e;

  // selects sub, sra and srai
  parameter logic [6:0] FUNCT7_ALT = 7'b0100000;

  // r-type view of an instruction word
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } insn_fields_t;

endpackage

`default_nettype wire
